//--- rtl/ts_pkg.sv
`default_nettype none

package ts_pkg;

	// memory depths and walk limits
	localparam int SFILE_AW = 8;
	localparam int TMB_AW = 7;
	localparam int SPR_LAST = 255;
	localparam int TM_TILES = 64;

	// layers in processing order, one bit each
	typedef enum logic [3:0]
	{
		L_TM = 4'b0001,
		L_S0 = 4'b0010,
		L_T0 = 4'b0100,
		L_S1 = 4'b1000
	} layer_e;

	// sprite file walk
	typedef enum logic [5:0]
	{
		SP_NONE   = 6'b000001,
		SP_R0_PRE = 6'b000010,
		SP_R0     = 6'b000100,
		SP_R1_PRE = 6'b001000,
		SP_R1     = 6'b010000,
		SP_R2     = 6'b100000
	} sprite_st_e;

	// per-frame configuration
	typedef struct packed
	{
		logic s_en;
		logic t_en;
		// draw tile number zero
		logic tz_en;
		logic [7:0] tm_page;
		logic [7:0] t_gpage;
		logic [7:0] s_gpage;
		logic [8:0] t_x_offs;
		logic [8:0] t_y_offs;
		logic [1:0] t_palsel;
		logic [5:0] num_tiles;
	} ts_cfg_t;

	// one renderer task
	typedef struct packed
	{
		logic [7:0] page;
		logic [8:0] line;
		logic [5:0] addr;
		logic [8:0] x;
		logic [2:0] xs;
		logic xf;
		logic [3:0] pal;
	} tsr_task_t;

	typedef struct packed
	{
		logic yflp;
		logic xflp;
		logic [1:0] pal;
		logic [11:0] tnum;
	} tile_desc_t;

	// sprite descriptor, three words per sprite
	typedef struct packed
	{
		logic yflp;
		logic leap;
		logic act;
		logic unused;
		logic [2:0] ysz;
		logic [8:0] ycrd;
	} spr_r0_t;

	typedef struct packed
	{
		logic xflp;
		logic [2:0] unused;
		logic [2:0] xsz;
		logic [8:0] xcrd;
	} spr_r1_t;

	typedef struct packed
	{
		logic [3:0] pal;
		logic [11:0] tnum;
	} spr_r2_t;

endpackage

`default_nettype wire

//--- rtl/ts_layer_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ts_layer_ctrl
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire v_ts,
	input wire v_pf,
	input wire ts_pkg::ts_cfg_t cfg,
	input wire tm_end,
	input wire s_end,
	input wire t_end,
	input wire ts_pkg::tsr_task_t s_task,
	input wire s_go,
	input wire ts_pkg::tsr_task_t t_task,
	input wire t_go,
	output logic tm_act,
	output logic s_act,
	output logic s_sel,
	output logic t_act,
	output logic tsr_go,
	output ts_pkg::tsr_task_t tsr,
	output logic busy
);

	ts_pkg::layer_e layer;
	logic [3:0] layer_bits;
	logic [3:0] layer_act;
	logic [3:0] layer_skip;
	logic [3:0] layer_ok;
	logic [3:0] layer_end;

	assign layer_bits = layer;

	// enabled and allowed, in layer_e bit order
	assign layer_ok = {cfg.s_en & v_ts, cfg.t_en & v_ts, cfg.s_en & v_ts, cfg.t_en & v_pf};
	// sprite end goes to whichever sprite layer is running
	assign layer_end = {s_end & s_sel, t_end, s_end & ~s_sel, tm_end};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			layer <= ts_pkg::layer_e'(4'b0000);
			layer_act <= 4'b0000;
			layer_skip <= 4'b0000;
		end
		else if (start)
		begin
			layer <= ts_pkg::L_TM;
			layer_act <= 4'b0000;
			layer_skip <= ~layer_ok;
		end
		else
		begin
			// step past a skipped or finished layer
			if (|(layer_bits & layer_skip))
				layer <= ts_pkg::layer_e'({layer_bits[2:0], 1'b0});
			layer_act <= layer_bits & ~(layer_skip | layer_end);
			layer_skip <= layer_skip | layer_end;
		end
	end

	assign tm_act = |(layer_act & ts_pkg::L_TM);
	assign s_act = |(layer_act & (ts_pkg::L_S0 | ts_pkg::L_S1));
	assign s_sel = |(layer_act & ts_pkg::L_S1);
	assign t_act = |(layer_act & ts_pkg::L_T0);
	assign busy = |layer_bits;

	// only the active processor can pulse go
	assign tsr_go = s_go | t_go;
	assign tsr = s_act ? s_task : t_task;

	a_act_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(layer_act));
	a_go_layer: assert property (@(posedge clk) disable iff (rst)
		tsr_go |-> |(layer_act & layer_bits & ~ts_pkg::L_TM));

endmodule

`default_nettype wire

//--- rtl/ts_tilemap_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module ts_tilemap_fetch
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire [8:0] line,
	input wire ts_pkg::ts_cfg_t cfg,
	input wire tm_act,
	input wire dram_next,
	output logic [20:0] dram_addr,
	output logic dram_req,
	output logic tm_end,
	output logic tmb_we,
	output logic [ts_pkg::TMB_AW-1:0] tmb_waddr
);

	logic [8:0] pf_line;
	logic [6:0] col;
	logic done;

	// the row shown by the tile layer eight lines from now
	assign pf_line = line + 9'd8 + cfg.t_y_offs;
	assign done = col == 7'(ts_pkg::TM_TILES);

	assign dram_req = tm_act & ~done;
	assign dram_addr = {cfg.tm_page, pf_line[8:3], col[5:0], 1'b0};
	assign tm_end = tm_act & done;

	// descriptor is written in the cycle it arrives
	assign tmb_we = dram_req & dram_next;
	assign tmb_waddr = {pf_line[3], col[5:0]};

	always_ff @(posedge clk)
	begin
		if (rst)
			col <= 7'd0;
		else if (start)
			col <= 7'd0;
		else if (tmb_we)
			col <= col + 7'd1;
	end

endmodule

`default_nettype wire

//--- rtl/ts_tile_buf.sv
`timescale 1ns/10ps
`default_nettype none

module ts_tile_buf
(
	input wire clk,
	input wire we,
	input wire [ts_pkg::TMB_AW-1:0] waddr,
	input wire [15:0] wdata,
	input wire [ts_pkg::TMB_AW-1:0] raddr,
	output logic [15:0] rdata
);

	// two tile rows, slot picked by the address msb
	logic [15:0] mem [0:(1 << ts_pkg::TMB_AW)-1];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- rtl/ts_tile_proc.sv
`timescale 1ns/10ps
`default_nettype none

module ts_tile_proc
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire [8:0] line,
	input wire ts_pkg::ts_cfg_t cfg,
	input wire t_act,
	input wire tsr_rdy,
	input wire [15:0] tmb_rdata,
	output logic [ts_pkg::TMB_AW-1:0] tmb_raddr,
	output logic t_go,
	output ts_pkg::tsr_task_t t_task,
	output logic t_end
);

	ts_pkg::tile_desc_t desc;
	logic [8:0] t_line;
	logic [5:0] tx;
	logic [5:0] cur;
	logic pre_valid;
	logic valid;
	logic drawn;
	logic good;
	logic skip;
	logic wait_rdy;

	assign desc = ts_pkg::tile_desc_t'(tmb_rdata);
	assign t_line = line + cfg.t_y_offs;
	assign tmb_raddr = {t_line[3], tx + cfg.t_x_offs[8:3]};

	// tx runs one ahead of the descriptor on rdata
	assign cur = tx - 6'd1;
	assign t_end = t_act & valid & (cur == cfg.num_tiles);
	assign drawn = (|desc.tnum) | cfg.tz_en;
	assign good = t_act & valid & ~t_end & drawn;
	assign skip = t_act & valid & ~t_end & ~drawn;
	assign t_go = good & tsr_rdy;
	assign wait_rdy = good & ~tsr_rdy;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tx <= 6'd0;
			pre_valid <= 1'b0;
			valid <= 1'b0;
		end
		else if (start)
		begin
			tx <= 6'd0;
			pre_valid <= 1'b1;
			valid <= 1'b0;
		end
		else if (t_act & pre_valid)
		begin
			tx <= tx + 6'd1;
			pre_valid <= 1'b0;
			valid <= 1'b1;
		end
		else if (wait_rdy)
		begin
			// step back so the held tile is read again
			tx <= tx - 6'd1;
			pre_valid <= 1'b1;
			valid <= 1'b0;
		end
		else if (t_go | skip)
			tx <= tx + 6'd1;
		else if (t_end)
			valid <= 1'b0;
	end

	always_comb
	begin
		t_task.page = cfg.t_gpage;
		t_task.line = {desc.tnum[11:6], t_line[2:0] ^ {3{desc.yflp}}};
		t_task.addr = desc.tnum[5:0];
		// fine scroll shifts every tile left
		t_task.x = {cur, 3'b000} - {6'd0, cfg.t_x_offs[2:0]};
		t_task.xs = 3'd0;
		t_task.xf = desc.xflp;
		t_task.pal = {cfg.t_palsel, desc.pal};
	end

endmodule

`default_nettype wire

//--- rtl/ts_sprite_file.sv
`timescale 1ns/10ps
`default_nettype none

module ts_sprite_file
(
	input wire clk,
	input wire we,
	input wire [ts_pkg::SFILE_AW-1:0] waddr,
	input wire [15:0] wdata,
	input wire [ts_pkg::SFILE_AW-1:0] raddr,
	output logic [15:0] rdata
);

	// three words per sprite, host side writes only
	logic [15:0] mem [0:(1 << ts_pkg::SFILE_AW)-1];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- rtl/ts_sprite_proc.sv
`timescale 1ns/10ps
`default_nettype none

module ts_sprite_proc
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire [8:0] line,
	input wire ts_pkg::ts_cfg_t cfg,
	input wire s_act,
	input wire tsr_rdy,
	input wire [15:0] sfile_rdata,
	output logic [ts_pkg::SFILE_AW-1:0] sfile_raddr,
	output logic s_go,
	output ts_pkg::tsr_task_t s_task,
	output logic s_end
);

	ts_pkg::sprite_st_e st;
	ts_pkg::spr_r0_t r0;
	ts_pkg::spr_r1_t r1;
	ts_pkg::spr_r2_t r2;
	logic [ts_pkg::SFILE_AW-1:0] sreg;
	logic last_r;
	logic [8:0] s_line;
	logic [5:0] s_ymax;
	logic [5:0] bm_offs;
	logic visible;
	logic in_r0;
	logic last;
	logic leap_r;
	logic [5:0] bm_offs_r;
	logic [8:0] x_r;
	logic [2:0] xs_r;
	logic xf_r;

	assign r0 = ts_pkg::spr_r0_t'(sfile_rdata);
	assign r1 = ts_pkg::spr_r1_t'(sfile_rdata);
	assign r2 = ts_pkg::spr_r2_t'(sfile_rdata);
	assign sfile_raddr = sreg;

	// sprite row hit by this video line
	assign s_line = line - r0.ycrd;
	assign s_ymax = {r0.ysz, 3'b111};
	assign visible = r0.act & (s_line <= {3'b000, s_ymax});
	assign bm_offs = r0.yflp ? (s_ymax - s_line[5:0]) : s_line[5:0];

	assign in_r0 = s_act & (st == ts_pkg::SP_R0);
	assign last = in_r0 & last_r;
	assign s_go = s_act & (st == ts_pkg::SP_R2) & tsr_rdy;

	// a finished walk also closes any later sprite layer
	assign s_end = (s_act & (st == ts_pkg::SP_NONE)) | last
		| (in_r0 & ~visible & r0.leap) | (s_go & leap_r);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			st <= ts_pkg::SP_NONE;
			sreg <= '0;
			last_r <= 1'b0;
		end
		else if (start)
		begin
			st <= ts_pkg::SP_R0_PRE;
			sreg <= '0;
			last_r <= 1'b0;
		end
		else if (s_act)
		begin
			// rdata next cycle comes from the address read now
			last_r <= sreg == ts_pkg::SFILE_AW'(ts_pkg::SPR_LAST);
			case (st)
				ts_pkg::SP_R0_PRE:
				begin
					sreg <= sreg + ts_pkg::SFILE_AW'(3);
					st <= ts_pkg::SP_R0;
				end
				ts_pkg::SP_R0:
				begin
					if (last_r)
						st <= ts_pkg::SP_NONE;
					else if (visible)
					begin
						// back to R1 of this sprite
						sreg <= sreg - ts_pkg::SFILE_AW'(2);
						st <= ts_pkg::SP_R1_PRE;
					end
					else if (r0.leap)
						st <= ts_pkg::SP_R0_PRE;
					else
						sreg <= sreg + ts_pkg::SFILE_AW'(3);
				end
				ts_pkg::SP_R1_PRE:
				begin
					sreg <= sreg + ts_pkg::SFILE_AW'(1);
					st <= ts_pkg::SP_R1;
				end
				ts_pkg::SP_R1:
					st <= ts_pkg::SP_R2;
				ts_pkg::SP_R2:
				begin
					// R2 is reread until the renderer takes it
					if (tsr_rdy)
					begin
						sreg <= sreg + ts_pkg::SFILE_AW'(1);
						st <= ts_pkg::SP_R0_PRE;
					end
				end
				default:
					st <= st;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_r0)
		begin
			leap_r <= r0.leap;
			bm_offs_r <= bm_offs;
		end
		if (s_act & (st == ts_pkg::SP_R1))
		begin
			x_r <= r1.xcrd;
			xs_r <= r1.xsz;
			xf_r <= r1.xflp;
		end
	end

	always_comb
	begin
		s_task.page = cfg.s_gpage;
		s_task.line = {r2.tnum[11:6], 3'b000} + {3'b000, bm_offs_r};
		s_task.addr = r2.tnum[5:0];
		s_task.x = x_r;
		s_task.xs = xs_r;
		s_task.xf = xf_r;
		s_task.pal = r2.pal;
	end

	a_st_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(st));

endmodule

`default_nettype wire

//--- rtl/ts_unit.sv
`timescale 1ns/10ps
`default_nettype none

module ts_unit
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire [8:0] line,
	input wire v_ts,
	input wire v_pf,
	input wire ts_pkg::ts_cfg_t cfg,
	input wire [ts_pkg::SFILE_AW-1:0] sfile_addr,
	input wire [15:0] sfile_data,
	input wire sfile_we,
	output logic tsr_go,
	output ts_pkg::tsr_task_t tsr,
	input wire tsr_rdy,
	output logic [20:0] dram_addr,
	output logic dram_req,
	input wire dram_next,
	input wire [15:0] dram_rdata,
	output logic busy
);

	logic tm_act;
	logic s_act;
	logic t_act;
	logic tm_end;
	logic s_end;
	logic t_end;
	logic s_go;
	logic t_go;
	ts_pkg::tsr_task_t s_task;
	ts_pkg::tsr_task_t t_task;
	logic tmb_we;
	logic [ts_pkg::TMB_AW-1:0] tmb_waddr;
	logic [ts_pkg::TMB_AW-1:0] tmb_raddr;
	logic [15:0] tmb_rdata;
	logic [ts_pkg::SFILE_AW-1:0] sfile_raddr;
	logic [15:0] sfile_rdata;

	ts_layer_ctrl i_ctrl
	(
		.clk(clk), .rst(rst), .start(start), .v_ts(v_ts), .v_pf(v_pf), .cfg(cfg),
		.tm_end(tm_end), .s_end(s_end), .t_end(t_end),
		.s_task(s_task), .s_go(s_go), .t_task(t_task), .t_go(t_go),
		.tm_act(tm_act), .s_act(s_act), .s_sel(), .t_act(t_act),
		.tsr_go(tsr_go), .tsr(tsr), .busy(busy)
	);

	ts_tilemap_fetch i_fetch
	(
		.clk(clk), .rst(rst), .start(start), .line(line), .cfg(cfg),
		.tm_act(tm_act), .dram_next(dram_next),
		.dram_addr(dram_addr), .dram_req(dram_req), .tm_end(tm_end),
		.tmb_we(tmb_we), .tmb_waddr(tmb_waddr)
	);

	// prefetched descriptors straight from the DRAM data bus
	ts_tile_buf i_tmb
	(
		.clk(clk), .we(tmb_we), .waddr(tmb_waddr), .wdata(dram_rdata),
		.raddr(tmb_raddr), .rdata(tmb_rdata)
	);

	ts_tile_proc i_tile
	(
		.clk(clk), .rst(rst), .start(start), .line(line), .cfg(cfg),
		.t_act(t_act), .tsr_rdy(tsr_rdy), .tmb_rdata(tmb_rdata),
		.tmb_raddr(tmb_raddr), .t_go(t_go), .t_task(t_task), .t_end(t_end)
	);

	ts_sprite_file i_sfile
	(
		.clk(clk), .we(sfile_we), .waddr(sfile_addr), .wdata(sfile_data),
		.raddr(sfile_raddr), .rdata(sfile_rdata)
	);

	ts_sprite_proc i_sprite
	(
		.clk(clk), .rst(rst), .start(start), .line(line), .cfg(cfg),
		.s_act(s_act), .tsr_rdy(tsr_rdy), .sfile_rdata(sfile_rdata),
		.sfile_raddr(sfile_raddr), .s_go(s_go), .s_task(s_task), .s_end(s_end)
	);

endmodule

`default_nettype wire

//--- testbench/tb_ts_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ts_unit;

	logic clk;
	logic rst;
	logic start;
	logic [8:0] line_in;
	logic v_ts;
	logic v_pf;
	ts_pkg::ts_cfg_t cfg;
	logic [ts_pkg::SFILE_AW-1:0] sfile_addr;
	logic [15:0] sfile_data;
	logic sfile_we;
	logic tsr_go;
	ts_pkg::tsr_task_t tsr;
	logic tsr_rdy;
	logic [20:0] dram_addr;
	logic dram_req;
	logic dram_next;
	logic [15:0] dram_rdata;
	logic busy;

	integer seed;
	int errors;
	logic bp_mode;
	logic saw_req;
	logic [15:0] sfile_img [0:255];
	ts_pkg::tsr_task_t got_q[$];
	ts_pkg::tsr_task_t exp_q[$];

	ts_unit i_dut
	(
		.clk(clk), .rst(rst), .start(start), .line(line_in), .v_ts(v_ts), .v_pf(v_pf),
		.cfg(cfg), .sfile_addr(sfile_addr), .sfile_data(sfile_data), .sfile_we(sfile_we),
		.tsr_go(tsr_go), .tsr(tsr), .tsr_rdy(tsr_rdy),
		.dram_addr(dram_addr), .dram_req(dram_req), .dram_next(dram_next),
		.dram_rdata(dram_rdata), .busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "mismatch");
		end
	endtask

	// tilemap word seen by the DRAM model at a given address
	function automatic logic [15:0] dram_word(input logic [20:0] a);
		logic [15:0] w;
		w = (a[15:0] * 16'd40503) ^ {11'd0, a[20:16]};
		// every fifth column holds tile zero
		if (a[6:1] % 5 == 0)
			w[11:0] = 12'd0;
		return w;
	endfunction

	// DRAM answers at random, never two words back to back
	always @(posedge clk)
	begin
		if (rst)
			dram_next <= 1'b0;
		else if (dram_next)
			dram_next <= 1'b0;
		else if (dram_req && (($random(seed) & 3) != 0))
		begin
			dram_next <= 1'b1;
			dram_rdata <= dram_word(dram_addr);
		end
		if (dram_req)
			saw_req <= 1'b1;
	end

	// renderer collects tasks and drops ready in back-pressure runs
	always @(posedge clk)
	begin
		if (rst)
			tsr_rdy <= 1'b1;
		else
		begin
			if (tsr_go)
			begin
				check(64'(tsr_rdy), 64'd1, "tsr_go while tsr_rdy low");
				got_q.push_back(tsr);
			end
			if (bp_mode)
				tsr_rdy <= ($random(seed) & 3) != 0;
			else
				tsr_rdy <= 1'b1;
		end
	end

	task automatic add_tile_tasks(input logic [8:0] ln, input ts_pkg::ts_cfg_t c);
		logic [8:0] tl;
		logic [5:0] col;
		logic [15:0] d;
		ts_pkg::tsr_task_t t;
		int i;
		tl = ln + c.t_y_offs;
		for (i = 0; i < int'(c.num_tiles); i++)
		begin
			col = 6'(i) + c.t_x_offs[8:3];
			d = dram_word({c.tm_page, tl[8:3], col, 1'b0});
			if (d[11:0] != 12'd0 || c.tz_en)
			begin
				t.page = c.t_gpage;
				t.line = {d[11:6], tl[2:0] ^ {3{d[15]}}};
				t.addr = d[5:0];
				t.x = 9'(i * 8) - {6'd0, c.t_x_offs[2:0]};
				t.xs = 3'd0;
				t.xf = d[14];
				t.pal = {c.t_palsel, d[13:12]};
				exp_q.push_back(t);
			end
		end
	endtask

	// sprites of one layer, a leap bit moves on to the next layer
	task automatic add_sprite_tasks(input logic [8:0] ln, input ts_pkg::ts_cfg_t c,
		input int want);
		logic [15:0] r0;
		logic [15:0] r1;
		logic [15:0] r2;
		logic [8:0] dy;
		logic [5:0] h;
		logic [5:0] row;
		ts_pkg::tsr_task_t t;
		int s;
		int layer;
		layer = 0;
		for (s = 0; s < ts_pkg::SPR_LAST / 3 && layer < 2; s++)
		begin
			r0 = sfile_img[3 * s];
			r1 = sfile_img[3 * s + 1];
			r2 = sfile_img[3 * s + 2];
			dy = ln - r0[8:0];
			h = {r0[11:9], 3'b111};
			if (r0[13] && dy <= {3'b000, h} && layer == want)
			begin
				row = r0[15] ? h - dy[5:0] : dy[5:0];
				t.page = c.s_gpage;
				t.line = {r2[11:6], 3'b000} + {3'b000, row};
				t.addr = r2[5:0];
				t.x = r1[8:0];
				t.xs = r1[11:9];
				t.xf = r1[15];
				t.pal = r2[15:12];
				exp_q.push_back(t);
			end
			if (r0[14])
				layer++;
		end
	endtask

	task automatic expect_line(input logic [8:0] ln, input ts_pkg::ts_cfg_t c,
		input logic vts);
		exp_q.delete();
		if (c.s_en && vts)
			add_sprite_tasks(ln, c, 0);
		if (c.t_en && vts)
			add_tile_tasks(ln, c);
		if (c.s_en && vts)
			add_sprite_tasks(ln, c, 1);
	endtask

	task automatic compare_tasks(input string what);
		int i;
		check(64'(got_q.size()), 64'(exp_q.size()), {what, " task count"});
		for (i = 0; i < exp_q.size(); i++)
			check(64'(got_q[i]), 64'(exp_q[i]), $sformatf("%s task %0d", what, i));
	endtask

	task automatic run_line(input logic [8:0] ln, input ts_pkg::ts_cfg_t c,
		input logic vts, input logic vpf);
		int n;
		got_q.delete();
		@(posedge clk);
		saw_req <= 1'b0;
		cfg <= c;
		line_in <= ln;
		v_ts <= vts;
		v_pf <= vpf;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		n = 0;
		do
		begin
			@(posedge clk);
			n++;
			// busy rises in the cycle after start
			if (n == 1)
				check(64'(busy), 64'd1, "busy in cycle after start");
			if (n > 20000)
			begin
				$display("timeout: busy never fell on line %0d", ln);
				$display("=== FAIL ===");
				$fatal(1, "timeout");
			end
		end
		while (busy);
	endtask

	task automatic write_word(input int a, input logic [15:0] w);
		@(posedge clk);
		sfile_we <= 1'b1;
		sfile_addr <= 8'(a);
		sfile_data <= w;
		sfile_img[a] = w;
		@(posedge clk);
		sfile_we <= 1'b0;
	endtask

	task automatic set_sprite(input int idx, input logic [15:0] r0, input logic [15:0] r1,
		input logic [15:0] r2);
		write_word(3 * idx, r0);
		write_word(3 * idx + 1, r1);
		write_word(3 * idx + 2, r2);
	endtask

	task automatic load_sprites();
		logic [15:0] w;
		int a;
		// fill keeps act and leap clear in every R0 word
		for (a = 0; a < 256; a++)
		begin
			w = {a[7:0], ~a[7:0]} ^ 16'h3c69;
			if (a % 3 == 0)
				w[14:13] = 2'b00;
			write_word(a, w);
		end
		set_sprite(0, {4'b0010, 3'd1, 9'd100}, {4'b0000, 3'd2, 9'd40}, {4'd3, 12'h1c5});
		set_sprite(1, {4'b0000, 3'd1, 9'd104}, {4'b0000, 3'd1, 9'd60}, {4'd5, 12'h0a1});
		set_sprite(2, {4'b0010, 3'd0, 9'd200}, {4'b0000, 3'd0, 9'd80}, {4'd6, 12'h222});
		set_sprite(3, {4'b1010, 3'd0, 9'd105}, {4'b0000, 3'd0, 9'd120}, {4'd7, 12'h3f0});
		set_sprite(4, {4'b0110, 3'd3, 9'd90}, {4'b1000, 3'd3, 9'd150}, {4'd9, 12'h4c2});
		set_sprite(5, {4'b0010, 3'd0, 9'd108}, {4'b0000, 3'd4, 9'd300}, {4'd10, 12'h515});
		set_sprite(6, {4'b0010, 3'd7, 9'd500}, {4'b0000, 3'd0, 9'd10}, {4'd11, 12'h606});
		set_sprite(7, {4'b1010, 3'd7, 9'd60}, {4'b1000, 3'd7, 9'd470}, {4'd12, 12'hfc3});
		set_sprite(84, {4'b0010, 3'd2, 9'd100}, {4'b0000, 3'd5, 9'd511}, {4'd15, 12'h8a8});
	endtask

	function automatic ts_pkg::ts_cfg_t base_cfg(input logic s_en, input logic t_en);
		ts_pkg::ts_cfg_t c;
		c.s_en = s_en;
		c.t_en = t_en;
		c.tz_en = 1'b0;
		c.tm_page = 8'h35;
		c.t_gpage = 8'h12;
		c.s_gpage = 8'h7a;
		c.t_x_offs = 9'd21;
		c.t_y_offs = 9'd13;
		c.t_palsel = 2'b10;
		c.num_tiles = 6'd40;
		return c;
	endfunction

	task automatic test_skip_rules();
		// outputs idle after reset
		check(64'(busy), 64'd0, "busy after reset");
		check(64'(dram_req), 64'd0, "dram_req after reset");
		check(64'(tsr_go), 64'd0, "tsr_go after reset");
		run_line(9'd100, base_cfg(1'b0, 1'b0), 1'b1, 1'b1);
		check(64'(got_q.size()), 64'd0, "tasks with all layers off");
		check(64'(saw_req), 64'd0, "dram_req with all layers off");
	endtask

	task automatic test_tiles();
		ts_pkg::ts_cfg_t c;
		c = base_cfg(1'b0, 1'b1);
		run_line(9'd100, c, 1'b0, 1'b1);
		check(64'(saw_req), 64'd1, "prefetch dram_req");
		check(64'(got_q.size()), 64'd0, "tasks on prefetch-only line");
		run_line(9'd108, c, 1'b1, 1'b0);
		expect_line(9'd108, c, 1'b1);
		compare_tasks("tiles");
		// tile zero drawn this time
		c.tz_en = 1'b1;
		run_line(9'd108, c, 1'b1, 1'b0);
		expect_line(9'd108, c, 1'b1);
		compare_tasks("tiles tz_en");
	endtask

	task automatic test_sprites();
		ts_pkg::ts_cfg_t c;
		c = base_cfg(1'b1, 1'b1);
		load_sprites();
		run_line(9'd108, c, 1'b1, 1'b1);
		expect_line(9'd108, c, 1'b1);
		compare_tasks("sprites");
	endtask

	task automatic test_back_pressure();
		ts_pkg::ts_cfg_t c;
		c = base_cfg(1'b1, 1'b1);
		bp_mode <= 1'b1;
		run_line(9'd108, c, 1'b1, 1'b1);
		bp_mode <= 1'b0;
		expect_line(9'd108, c, 1'b1);
		compare_tasks("back-pressure");
	endtask

	task automatic test_sprite_only();
		ts_pkg::ts_cfg_t c;
		c = base_cfg(1'b1, 1'b0);
		// leap on an inactive sprite still splits the layers
		write_word(12, {4'b0100, 3'd3, 9'd90});
		run_line(9'd108, c, 1'b1, 1'b1);
		expect_line(9'd108, c, 1'b1);
		compare_tasks("sprite-only");
		check(64'(saw_req), 64'd0, "dram_req with tiles off");
	endtask

	initial
	begin
		seed = 14993;
		errors = 0;
		rst = 1'b1;
		start = 1'b0;
		line_in = 9'd0;
		v_ts = 1'b0;
		v_pf = 1'b0;
		cfg = '0;
		sfile_addr = '0;
		sfile_data = 16'd0;
		sfile_we = 1'b0;
		tsr_rdy = 1'b1;
		dram_next = 1'b0;
		dram_rdata = 16'd0;
		bp_mode = 1'b0;
		saw_req = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		test_skip_rules();
		test_tiles();
		test_sprites();
		test_back_pressure();
		test_sprite_only();
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- ts_unit.f
rtl/ts_pkg.sv
rtl/ts_layer_ctrl.sv
rtl/ts_tilemap_fetch.sv
rtl/ts_tile_buf.sv
rtl/ts_tile_proc.sv
rtl/ts_sprite_file.sv
rtl/ts_sprite_proc.sv
rtl/ts_unit.sv
testbench/tb_ts_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ts_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ts_unit \
	-f ts_unit.f -o tb_ts_unit > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/tb_ts_unit > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulator returned status $sim_status"
	exit 1
fi
exit 0
